//--- verilog.f
logic/hv_pkg.sv
logic/hv_fault_filter.sv
logic/hv_reg_slv.sv
logic/hv_ctrl_unit.sv
logic/hv_intb_encode.sv
logic/hv_core.sv
verification/hv_core_tb.sv

//--- verification/hv_core_cases.txt
# id fault_vec(hex) pulse_cycles config(hex) mode(hex) exp_status(hex) exp_state exp_width_sel
# fault_vec bits 5..0 scp desat oc ot vcc_ov vcc_uv, state 0 cfg 1 normal 2 fault
1 01 3 00 00 00 0 0
2 01 7 00 00 01 0 0
3 02 7 00 00 02 0 0
4 04 7 00 00 04 0 0
5 08 7 00 00 08 0 0
6 10 7 00 00 10 0 0
7 20 7 00 00 20 0 0
8 10 3 00 01 00 1 0
9 08 7 08 01 00 1 0
10 00 0 a5 f3 00 1 2
11 08 7 00 01 08 2 0
12 20 7 80 01 20 2 2
13 01 7 c2 01 01 2 3
14 03 7 42 01 01 2 1

//--- verification/hv_core_tb.sv
// hv core testbench
`timescale 1ns/100ps
module hv_core_tb;
    import hv_pkg::*;

    localparam int TIMEOUT_CYC = 300;
    localparam int SETTLE_CYC  = SYNC_STAGES + FLT_FILT_CYCLES + 4;   // filter to state
    localparam int SIG_ACK     = 0;
    localparam int SIG_PWM     = 1;
    localparam int SIG_INTB    = 2;

    logic              i_clk;
    logic              i_reset;
    logic              i_hv_vcc_uv;
    logic              i_hv_vcc_ov;
    logic              i_hv_ot;
    logic              i_hv_oc;
    logic              i_hv_desat_flt;
    logic              i_hv_scp_flt;
    logic              i_host_req;
    host_cmd_t         i_host_cmd;
    logic              o_host_ack;
    logic [REG_DW-1:0] o_host_rdata;
    logic              o_dgt_ang_pwm_en;
    logic              o_pwmn_intb;

    int err_cnt  = 0;
    int pass_cnt = 0;
    int fail_cnt = 0;
    int low_run  = 0;
    int last_low = 0;   // width of the last intb low phase

    hv_core dut_i (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_hv_vcc_uv      (i_hv_vcc_uv),
        .i_hv_vcc_ov      (i_hv_vcc_ov),
        .i_hv_ot          (i_hv_ot),
        .i_hv_oc          (i_hv_oc),
        .i_hv_desat_flt   (i_hv_desat_flt),
        .i_hv_scp_flt     (i_hv_scp_flt),
        .i_host_req       (i_host_req),
        .i_host_cmd       (i_host_cmd),
        .o_host_ack       (o_host_ack),
        .o_host_rdata     (o_host_rdata),
        .o_dgt_ang_pwm_en (o_dgt_ang_pwm_en),
        .o_pwmn_intb      (o_pwmn_intb)
    );

    initial begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;
    end

    // intb low width, counted on falling clock edges
    always @(negedge i_clk) begin
        if (i_reset) begin
            low_run = 0;
        end else if (!o_pwmn_intb) begin
            low_run = low_run + 1;
        end else if (low_run != 0) begin
            last_low = low_run;
            low_run  = 0;
        end
    end

    // ============================================================
    // helpers
    // ============================================================
    task automatic fail_timeout(input string what);
        $display("timeout at %0t ns while waiting for %s", $time, what);
        $display("Simulation failed");
        $finish;
    endtask

    task automatic check_val(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
        if (exp_v !== act_v) begin
            $display("[ERROR] %0t ns %s expected 0x%0h actual 0x%0h",
                     $time, name, exp_v, act_v);
            err_cnt++;
        end
    endtask

    function automatic logic sample_output(input int sel);
        case (sel)
            SIG_ACK: sample_output = o_host_ack;
            SIG_PWM: sample_output = o_dgt_ang_pwm_en;
            default: sample_output = o_pwmn_intb;
        endcase
    endfunction

    task automatic wait_level(input int sel, input logic level, input string what);
        int n;
        n = 0;
        while (sample_output(sel) !== level) begin
            @(posedge i_clk);
            #1;
            n++;
            if (n > TIMEOUT_CYC) begin
                fail_timeout(what);
            end
        end
    endtask

    // four-phase req/ack access
    task automatic host_access(input logic wr, input reg_addr_e addr,
                               input logic [7:0] wdata, output logic [7:0] rdata);
        @(posedge i_clk);
        #1;
        i_host_cmd.wr    = wr;
        i_host_cmd.addr  = addr;
        i_host_cmd.wdata = wdata;
        i_host_req       = 1'b1;
        wait_level(SIG_ACK, 1'b1, "host ack high");
        rdata      = o_host_rdata;
        i_host_req = 1'b0;
        wait_level(SIG_ACK, 1'b0, "host ack low");
    endtask

    task automatic set_pins(input logic [7:0] vec);
        i_hv_vcc_uv    = vec[0];
        i_hv_vcc_ov    = vec[1];
        i_hv_ot        = vec[2];
        i_hv_oc        = vec[3];
        i_hv_desat_flt = vec[4];
        i_hv_scp_flt   = vec[5];
    endtask

    task automatic pulse_faults(input logic [7:0] vec, input int len);
        if (len > 0) begin
            @(posedge i_clk);
            #1;
            set_pins(vec);
            repeat (len) @(posedge i_clk);
            #1;
            set_pins(8'h00);
        end
    endtask

    task automatic report_test(input int id, input int errs_before);
        if (err_cnt == errs_before) begin
            pass_cnt++;
            $display("test %0d passed", id);
        end else begin
            fail_cnt++;
            $display("test %0d failed with %0d errors", id, err_cnt - errs_before);
        end
    endtask

    // ============================================================
    // one case from the data file
    // ============================================================
    task automatic run_case(input int id, input logic [7:0] flt, input int len,
                            input logic [7:0] cfg, input logic [7:0] mode,
                            input logic [7:0] status, input int st, input int sel);
        int         errs_before;
        int         min_low;
        logic [7:0] rd;
        errs_before = err_cnt;
        min_low     = 8 << sel;   // 8, 16, 32, 64 cycles
        last_low    = 0;
        host_access(1'b1, ADDR_CONFIG, cfg, rd);
        host_access(1'b0, ADDR_CONFIG, 8'h00, rd);
        check_val("config readback", cfg, rd);
        host_access(1'b1, ADDR_MODE, mode, rd);
        host_access(1'b0, ADDR_MODE, 8'h00, rd);
        check_val("mode readback", mode & 8'hfd, rd);   // reset_req reads 0
        if (mode[0]) begin
            wait_level(SIG_PWM, 1'b1, "pwm enable high");
        end
        pulse_faults(flt, len);
        if (st == ST_FAULT) begin
            wait_level(SIG_PWM, 1'b0, "pwm enable low");
            wait_level(SIG_INTB, 1'b0, "intb low");
        end else begin
            repeat (SETTLE_CYC) @(posedge i_clk);
            #1;
        end
        host_access(1'b0, ADDR_FLT_STATUS, 8'h00, rd);
        check_val("fault status", status, rd);
        host_access(1'b0, ADDR_CTRL_STATUS, 8'h00, rd);
        check_val("ctrl state", st, rd);
        check_val("intb_width_sel", sel, dut_i.intb_width_sel);
        if (status != 8'h00) begin
            host_access(1'b1, ADDR_FLT_STATUS, status, rd);   // write one to clear
            host_access(1'b0, ADDR_FLT_STATUS, 8'h00, rd);
            check_val("fault status after clear", 0, rd);
        end
        host_access(1'b1, ADDR_MODE, 8'h02, rd);   // reset_req, normal_en off
        host_access(1'b0, ADDR_CTRL_STATUS, 8'h00, rd);
        check_val("ctrl state after reset_req", ST_CFG, rd);
        check_val("o_dgt_ang_pwm_en", 0, o_dgt_ang_pwm_en);
        if (st == ST_FAULT) begin
            wait_level(SIG_INTB, 1'b1, "intb release");
            @(posedge i_clk);
            #1;
            if (last_low < min_low) begin
                $display("intb was low for only %0d cycles in test %0d, minimum is %0d",
                         last_low, id, min_low);
                err_cnt++;
            end
        end
        report_test(id, errs_before);
    endtask

    // ============================================================
    // main sequence
    // ============================================================
    initial begin
        int         fd;
        int         code;
        int         n;
        int         id;
        int         len;
        int         st;
        int         sel;
        string      line;
        logic [7:0] flt;
        logic [7:0] cfg;
        logic [7:0] mode;
        logic [7:0] status;
        logic [7:0] rd;
        i_reset    = 1'b1;
        i_host_req = 1'b0;
        i_host_cmd = '0;
        set_pins(8'h00);
        repeat (2) @(posedge i_clk);
        #1;
        i_reset = 1'b0;

        // reset values
        n = err_cnt;
        check_val("o_dgt_ang_pwm_en", 0, o_dgt_ang_pwm_en);
        check_val("o_pwmn_intb", 1, o_pwmn_intb);
        check_val("o_host_ack", 0, o_host_ack);
        for (int a = 0; a < 4; a++) begin
            host_access(1'b0, reg_addr_e'(a), 8'h00, rd);
            check_val("register after reset", 0, rd);
        end
        report_test(0, n);

        fd = $fopen("verification/hv_core_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open verification/hv_core_cases.txt");
            $display("Simulation failed");
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                if (code > 0 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%d %h %d %h %h %h %d %d",
                                id, flt, len, cfg, mode, status, st, sel);
                    if (n == 8) begin
                        run_case(id, flt, len, cfg, mode, status, st, sel);
                    end
                end
            end
            $fclose(fd);

            $display("tests passed: %0d, tests failed: %0d", pass_cnt, fail_cnt);
            if (fail_cnt == 0) begin
                $display("Simulation completed successfully");
            end else begin
                $display("Simulation failed");
            end
        end
        $finish;
    end

endmodule

//--- logic/hv_core.sv
// hv die fault path top
`timescale 1ns/100ps
module hv_core (
    input  logic                      i_clk,
    input  logic                      i_reset,
    input  logic                      i_hv_vcc_uv,
    input  logic                      i_hv_vcc_ov,
    input  logic                      i_hv_ot,
    input  logic                      i_hv_oc,
    input  logic                      i_hv_desat_flt,
    input  logic                      i_hv_scp_flt,
    input  logic                      i_host_req,
    input  hv_pkg::host_cmd_t         i_host_cmd,
    output logic                      o_host_ack,
    output logic [hv_pkg::REG_DW-1:0] o_host_rdata,
    output logic                      o_dgt_ang_pwm_en,
    output logic                      o_pwmn_intb
);
    import hv_pkg::*;

    flt_vec_t    flt_evt;
    mode_t       mode;
    logic        reset_strobe;
    logic        flt_active;
    ctrl_state_e state;
    logic        intb_req;
    logic [1:0]  intb_width_sel;

    // ==========================================================
    // filter -> register slave -> control -> intb
    // ==========================================================
    hv_fault_filter u_hv_fault_filter (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_hv_vcc_uv      (i_hv_vcc_uv),
        .i_hv_vcc_ov      (i_hv_vcc_ov),
        .i_hv_ot          (i_hv_ot),
        .i_hv_oc          (i_hv_oc),
        .i_hv_desat_flt   (i_hv_desat_flt),
        .i_hv_scp_flt     (i_hv_scp_flt),
        .o_flt_evt        (flt_evt)
    );

    hv_reg_slv u_hv_reg_slv (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_host_req       (i_host_req),
        .i_host_cmd       (i_host_cmd),
        .o_host_ack       (o_host_ack),
        .o_host_rdata     (o_host_rdata),
        .i_flt_evt        (flt_evt),
        .i_state          (state),
        .o_mode           (mode),
        .o_reset_strobe   (reset_strobe),
        .o_flt_active     (flt_active),
        .o_intb_width_sel (intb_width_sel)
    );

    hv_ctrl_unit u_hv_ctrl_unit (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_mode           (mode),
        .i_reset_strobe   (reset_strobe),
        .i_flt_active     (flt_active),
        .o_state          (state),
        .o_pwm_en         (o_dgt_ang_pwm_en),
        .o_intb_req       (intb_req)
    );

    hv_intb_encode u_hv_intb_encode (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_intb_req       (intb_req),
        .i_width_sel      (intb_width_sel),
        .o_pwmn_intb      (o_pwmn_intb)
    );

endmodule

//--- logic/hv_intb_encode.sv
// interrupt line with minimum low width
`timescale 1ns/100ps
module hv_intb_encode (
    input  logic       i_clk,
    input  logic       i_reset,
    input  logic       i_intb_req,
    input  logic [1:0] i_width_sel,
    output logic       o_pwmn_intb
);
    import hv_pkg::*;

    logic [1:0]            sel_q;     // width captured at falling edge
    logic [INTB_CNT_W-1:0] low_cnt_q;
    logic [INTB_CNT_W-1:0] min_low;

    assign min_low = INTB_MIN_LOW[sel_q];

    // ==========================================================
    // line control
    // ==========================================================
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_pwmn_intb <= 1'b1;
            sel_q       <= '0;
            low_cnt_q   <= '0;
        end else if (o_pwmn_intb) begin
            if (i_intb_req) begin
                o_pwmn_intb <= 1'b0;
                sel_q       <= i_width_sel;
                low_cnt_q   <= INTB_CNT_W'(1);
            end
        end else begin
            if (!i_intb_req && low_cnt_q >= min_low) begin
                o_pwmn_intb <= 1'b1;
            end else if (low_cnt_q < min_low) begin
                low_cnt_q <= low_cnt_q + 1'b1;   // stops at the minimum
            end
        end
    end

endmodule

//--- logic/hv_ctrl_unit.sv
// operating state machine
`timescale 1ns/100ps
module hv_ctrl_unit (
    input  logic                i_clk,
    input  logic                i_reset,
    input  hv_pkg::mode_t       i_mode,
    input  logic                i_reset_strobe,
    input  logic                i_flt_active,
    output hv_pkg::ctrl_state_e o_state,
    output logic                o_pwm_en,
    output logic                o_intb_req
);
    import hv_pkg::*;

    ctrl_state_e state_nxt;

    // ==========================================================
    // next state
    // ==========================================================
    always_comb begin
        state_nxt = o_state;
        case (o_state)
            ST_CFG: begin
                if (i_mode.normal_en && !i_flt_active) begin
                    state_nxt = ST_NORMAL;
                end
            end
            ST_NORMAL: begin
                if (i_flt_active) begin
                    state_nxt = ST_FAULT;      // fault has priority
                end else if (!i_mode.normal_en) begin
                    state_nxt = ST_CFG;
                end
            end
            ST_FAULT: begin
                // leave only once the status is clean
                if (i_reset_strobe && !i_flt_active) begin
                    state_nxt = ST_CFG;
                end
            end
            default: begin
                state_nxt = ST_CFG;
            end
        endcase
    end

    // ==========================================================
    // state and outputs
    // ==========================================================
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_state    <= ST_CFG;
            o_pwm_en   <= 1'b0;
            o_intb_req <= 1'b0;
        end else begin
            o_state    <= state_nxt;
            o_pwm_en   <= (state_nxt == ST_NORMAL);   // aligned with state
            o_intb_req <= (state_nxt == ST_FAULT);
        end
    end

endmodule

//--- logic/hv_reg_slv.sv
// host register port and fault status
`timescale 1ns/100ps
module hv_reg_slv (
    input  logic                      i_clk,
    input  logic                      i_reset,
    input  logic                      i_host_req,
    input  hv_pkg::host_cmd_t         i_host_cmd,
    output logic                      o_host_ack,
    output logic [hv_pkg::REG_DW-1:0] o_host_rdata,
    input  hv_pkg::flt_vec_t          i_flt_evt,
    input  hv_pkg::ctrl_state_e       i_state,
    output hv_pkg::mode_t             o_mode,
    output logic                      o_reset_strobe,
    output logic                      o_flt_active,
    output logic [1:0]                o_intb_width_sel
);
    import hv_pkg::*;

    logic               acc_en;
    logic               wr_en;
    mode_t              cmd_mode;
    mode_t              mode_q;
    cfg_t               cfg_q;
    logic [FLT_NUM-1:0] status_q;
    logic [FLT_NUM-1:0] status_nxt;
    logic [FLT_NUM-1:0] w1c;
    logic [REG_DW-1:0]  rdata_nxt;

    // ==========================================================
    // four-phase handshake
    // ==========================================================
    assign acc_en   = i_host_req && !o_host_ack;   // first sample of req
    assign wr_en    = acc_en && i_host_cmd.wr;
    assign cmd_mode = mode_t'(i_host_cmd.wdata);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_host_ack <= 1'b0;
        end else if (acc_en) begin
            o_host_ack <= 1'b1;
        end else if (!i_host_req) begin
            o_host_ack <= 1'b0;
        end
    end

    // read mux, sampled on the access edge
    always_comb begin
        case (i_host_cmd.addr)
            ADDR_MODE:        rdata_nxt = mode_q;
            ADDR_FLT_STATUS:  rdata_nxt = {{(REG_DW-FLT_NUM){1'b0}}, status_q};
            ADDR_CTRL_STATUS: rdata_nxt = {{(REG_DW-2){1'b0}}, i_state};
            ADDR_CONFIG:      rdata_nxt = cfg_q;
            default:          rdata_nxt = '0;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_host_rdata <= '0;
        end else if (acc_en && !i_host_cmd.wr) begin
            o_host_rdata <= rdata_nxt;
        end
    end

    // ==========================================================
    // mode and config registers
    // ==========================================================
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            mode_q         <= '0;
            cfg_q          <= '0;
            o_reset_strobe <= 1'b0;
        end else begin
            o_reset_strobe <= 1'b0;
            if (wr_en && i_host_cmd.addr == ADDR_MODE) begin
                mode_q <= '{reserved:  cmd_mode.reserved,
                            reset_req: 1'b0,
                            normal_en: cmd_mode.normal_en};
                o_reset_strobe <= cmd_mode.reset_req;   // one cycle
            end
            if (wr_en && i_host_cmd.addr == ADDR_CONFIG) begin
                cfg_q <= cfg_t'(i_host_cmd.wdata);
            end
        end
    end

    // ==========================================================
    // sticky fault status
    // ==========================================================
    assign w1c = (wr_en && i_host_cmd.addr == ADDR_FLT_STATUS) ?
                 i_host_cmd.wdata[FLT_NUM-1:0] : '0;

    // a fault still present wins over the clear
    assign status_nxt = (status_q & ~w1c) | (i_flt_evt & ~cfg_q.flt_mask);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            status_q     <= '0;
            o_flt_active <= 1'b0;
        end else begin
            status_q     <= status_nxt;
            o_flt_active <= |(status_nxt & ~cfg_q.flt_mask);
        end
    end

    assign o_mode           = mode_q;
    assign o_intb_width_sel = cfg_q.intb_width_sel;

endmodule

//--- logic/hv_fault_filter.sv
// fault input synchronizer and deglitch
`timescale 1ns/100ps
module hv_fault_filter (
    input  logic             i_clk,
    input  logic             i_reset,
    input  logic             i_hv_vcc_uv,
    input  logic             i_hv_vcc_ov,
    input  logic             i_hv_ot,
    input  logic             i_hv_oc,
    input  logic             i_hv_desat_flt,
    input  logic             i_hv_scp_flt,
    output hv_pkg::flt_vec_t o_flt_evt
);
    import hv_pkg::*;

    flt_vec_t                                raw;
    logic [SYNC_STAGES-1:0][FLT_NUM-1:0]     sync_q;
    logic [FLT_NUM-1:0]                      sync_out;
    logic [FLT_NUM-1:0][FLT_CNT_W-1:0]       cnt_q;
    logic [FLT_NUM-1:0]                      evt_q;

    // pins into struct order
    assign raw.scp    = i_hv_scp_flt;
    assign raw.desat  = i_hv_desat_flt;
    assign raw.oc     = i_hv_oc;
    assign raw.ot     = i_hv_ot;
    assign raw.vcc_ov = i_hv_vcc_ov;
    assign raw.vcc_uv = i_hv_vcc_uv;

    // ==========================================================
    // synchronizer
    // ==========================================================
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[SYNC_STAGES-2:0], raw};
        end
    end

    assign sync_out = sync_q[SYNC_STAGES-1];

    // ==========================================================
    // deglitch counters
    // ==========================================================
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            cnt_q <= '0;
            evt_q <= '0;
        end else begin
            for (int i = 0; i < FLT_NUM; i++) begin
                if (!sync_out[i]) begin
                    cnt_q[i] <= '0;             // low sample restarts
                end else if (cnt_q[i] < FLT_CNT_W'(FLT_FILT_CYCLES)) begin
                    cnt_q[i] <= cnt_q[i] + 1'b1;
                end
                // this sample completes the run of high samples
                evt_q[i] <= sync_out[i] &&
                            (cnt_q[i] >= FLT_CNT_W'(FLT_FILT_CYCLES - 1));
            end
        end
    end

    assign o_flt_evt = flt_vec_t'(evt_q);

endmodule

//--- logic/hv_pkg.sv
// hv die fault path definitions
package hv_pkg;

    // ==========================================================
    // widths and counts
    // ==========================================================
    localparam int REG_DW          = 8;
    localparam int REG_AW          = 2;
    localparam int FLT_NUM         = 6;
    localparam int SYNC_STAGES     = 2;
    localparam int FLT_FILT_CYCLES = 4;   // deglitch length
    localparam int FLT_CNT_W       = $clog2(FLT_FILT_CYCLES + 1);

    // intb minimum low width in cycles, indexed by intb_width_sel
    localparam int INTB_CNT_W = 7;
    localparam logic [3:0][INTB_CNT_W-1:0] INTB_MIN_LOW = {
        INTB_CNT_W'(64),
        INTB_CNT_W'(32),
        INTB_CNT_W'(16),
        INTB_CNT_W'(8)
    };

    // ==========================================================
    // enums
    // ==========================================================
    typedef enum logic [REG_AW-1:0] {
        ADDR_MODE        = 2'd0,
        ADDR_FLT_STATUS  = 2'd1,
        ADDR_CTRL_STATUS = 2'd2,
        ADDR_CONFIG      = 2'd3
    } reg_addr_e;

    typedef enum logic [1:0] {
        ST_CFG    = 2'd0,
        ST_NORMAL = 2'd1,
        ST_FAULT  = 2'd2
    } ctrl_state_e;

    // ==========================================================
    // structs
    // ==========================================================
    typedef struct packed {
        logic scp;
        logic desat;
        logic oc;
        logic ot;
        logic vcc_ov;
        logic vcc_uv;   // bit 0
    } flt_vec_t;

    typedef struct packed {
        logic              wr;      // 1 write, 0 read
        reg_addr_e         addr;
        logic [REG_DW-1:0] wdata;
    } host_cmd_t;

    typedef struct packed {
        logic [REG_DW-3:0] reserved;
        logic              reset_req;   // strobe, reads 0
        logic              normal_en;
    } mode_t;

    typedef struct packed {
        logic [1:0] intb_width_sel;
        flt_vec_t   flt_mask;           // 1 masks the fault
    } cfg_t;

endpackage
